// ==== rtl/ctrl_reg_pkg.sv ====
// Register map and register bus types of the DMA control block
`default_nettype none

package ctrl_reg_pkg;

    localparam int REG_ADDR_W = 16;
    localparam int REG_DATA_W = 32;

    localparam logic [REG_ADDR_W-1:0] ADDR_ENABLE     = 16'h0000;

    // read descriptor block
    localparam logic [REG_ADDR_W-1:0] ADDR_RD_PCIE_LO = 16'h0100;
    localparam logic [REG_ADDR_W-1:0] ADDR_RD_PCIE_HI = 16'h0104;
    localparam logic [REG_ADDR_W-1:0] ADDR_RD_AXI     = 16'h0108;
    localparam logic [REG_ADDR_W-1:0] ADDR_RD_LEN     = 16'h0110;
    localparam logic [REG_ADDR_W-1:0] ADDR_RD_TAG     = 16'h0114;
    localparam logic [REG_ADDR_W-1:0] ADDR_RD_STATUS  = 16'h0118;

    // write descriptor block, same layout one page up
    localparam logic [REG_ADDR_W-1:0] ADDR_WR_PCIE_LO = 16'h0200;
    localparam logic [REG_ADDR_W-1:0] ADDR_WR_PCIE_HI = 16'h0204;
    localparam logic [REG_ADDR_W-1:0] ADDR_WR_AXI     = 16'h0208;
    localparam logic [REG_ADDR_W-1:0] ADDR_WR_LEN     = 16'h0210;
    localparam logic [REG_ADDR_W-1:0] ADDR_WR_TAG     = 16'h0214;
    localparam logic [REG_ADDR_W-1:0] ADDR_WR_STATUS  = 16'h0218;

    // packet counters
    localparam logic [REG_ADDR_W-1:0] ADDR_CNT_RQ     = 16'h0400;
    localparam logic [REG_ADDR_W-1:0] ADDR_CNT_RC     = 16'h0404;
    localparam logic [REG_ADDR_W-1:0] ADDR_CNT_CQ     = 16'h0408;
    localparam logic [REG_ADDR_W-1:0] ADDR_CNT_CC     = 16'h040C;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
    } reg_wr_t;

    // completion status as seen by software
    typedef struct packed {
        logic        done;
        logic [14:0] fill;
        logic [7:0]  err;
        logic [7:0]  tag;
    } status_view_t;

    typedef union packed {
        logic [REG_DATA_W-1:0] raw;
        status_view_t          status;
    } reg_word_u;

endpackage

`default_nettype wire

// ==== rtl/pcie_dma_pkg.sv ====
// Widths and handshake structs of the PCIe DMA engine and its links
`default_nettype none

package pcie_dma_pkg;

    localparam int PCIE_ADDR_W = 64;
    localparam int AXI_ADDR_W  = 32;
    localparam int DMA_LEN_W   = 16;
    localparam int DMA_TAG_W   = 8;
    localparam int DMA_ERR_W   = 4;
    localparam int CNT_W       = 32;
    localparam int ERR_SRC_N   = 3;
    localparam int MERGE_CNT_W = 4;

    typedef struct packed {
        logic [PCIE_ADDR_W-1:0] pcie_addr;
        logic [AXI_ADDR_W-1:0]  axi_addr;
        logic [DMA_LEN_W-1:0]   len;
        logic [DMA_TAG_W-1:0]   tag;
        logic                   valid;
    } dma_desc_t;

    typedef struct packed {
        logic [DMA_TAG_W-1:0] tag;
        logic [DMA_ERR_W-1:0] error;
        logic                 valid;
    } dma_status_t;

    // handshake as observed on one stream link
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } link_beat_t;

endpackage

`default_nettype wire

// ==== rtl/axil_reg_slave.sv ====
// Register bus slave
// one write and one read in flight, response held until the host takes it
`timescale 1ns/100ps
`default_nettype none

module axil_reg_slave (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  aw_valid,
    output logic                                 aw_ready,
    output logic                                 w_ready,
    output logic                                 b_valid,
    input  wire                                  b_ready,
    input  wire                                  ar_valid,
    input  wire [ctrl_reg_pkg::REG_ADDR_W-1:0]   ar_addr,
    output logic                                 ar_ready,
    output logic                                 r_valid,
    output logic [ctrl_reg_pkg::REG_DATA_W-1:0]  r_data,
    input  wire                                  r_ready,
    output logic                                 wr_stb,
    output logic                                 rd_stb,
    output logic [ctrl_reg_pkg::REG_ADDR_W-1:0]  rd_addr,
    input  wire ctrl_reg_pkg::reg_word_u         rd_data
);

    // accept only while no response is pending
    assign wr_stb  = aw_valid && !b_valid;
    assign rd_stb  = ar_valid && !r_valid;
    assign rd_addr = ar_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            aw_ready <= wr_stb;
            w_ready  <= wr_stb;
            b_valid  <= wr_stb || (b_valid && !b_ready);
            ar_ready <= rd_stb;
            r_valid  <= rd_stb || (r_valid && !r_ready);
        end
    end

    // read word captured on accept
    always_ff @(posedge clk) begin
        if (rd_stb) begin
            r_data <= rd_data.raw;
        end
    end

    // a pending write response stays up and blocks the next write
    assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && !aw_ready);

endmodule

`default_nettype wire

// ==== rtl/dma_ctrl_regs.sv ====
// DMA control register bank
// enable, descriptor staging and launch, completion status capture and irq
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl_regs (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 wr_stb,
    input  wire ctrl_reg_pkg::reg_wr_t          wr,
    input  wire                                 rd_stb,
    input  wire [ctrl_reg_pkg::REG_ADDR_W-1:0]  rd_addr,
    output ctrl_reg_pkg::reg_word_u             rd_data,
    output pcie_dma_pkg::dma_desc_t             rd_desc,
    output pcie_dma_pkg::dma_desc_t             wr_desc,
    input  wire                                 rd_desc_ready,
    input  wire                                 wr_desc_ready,
    input  wire pcie_dma_pkg::dma_status_t      rd_status,
    input  wire pcie_dma_pkg::dma_status_t      wr_status,
    input  wire [pcie_dma_pkg::CNT_W-1:0]       cnt_rq,
    input  wire [pcie_dma_pkg::CNT_W-1:0]       cnt_rc,
    input  wire [pcie_dma_pkg::CNT_W-1:0]       cnt_cq,
    input  wire [pcie_dma_pkg::CNT_W-1:0]       cnt_cc,
    output logic                                dma_enable,
    output logic                                irq
);

    // index 0 is the read side, index 1 the write side
    pcie_dma_pkg::dma_desc_t             stage_q  [2];
    pcie_dma_pkg::dma_desc_t             desc_q   [2];
    pcie_dma_pkg::dma_status_t           stat_q   [2];
    pcie_dma_pkg::dma_status_t           stat_in  [2];
    logic [ctrl_reg_pkg::REG_ADDR_W-1:0] wr_norm  [2];
    logic [ctrl_reg_pkg::REG_ADDR_W-1:0] rd_norm  [2];
    logic [1:0]                          desc_ready;
    logic [1:0]                          tag_wr;
    logic [1:0]                          stat_clr;
    logic [ctrl_reg_pkg::REG_DATA_W-1:0] enable_q;

    // write block decodes like the read block after removing its offset
    function automatic logic [ctrl_reg_pkg::REG_ADDR_W-1:0] blk_ofs(input int side);
        if (side == 0) begin
            return '0;
        end
        return ctrl_reg_pkg::ADDR_WR_PCIE_LO - ctrl_reg_pkg::ADDR_RD_PCIE_LO;
    endfunction

    function automatic pcie_dma_pkg::dma_desc_t stage_field(
        input pcie_dma_pkg::dma_desc_t             d,
        input logic [ctrl_reg_pkg::REG_ADDR_W-1:0] addr,
        input logic [ctrl_reg_pkg::REG_DATA_W-1:0] data
    );
        pcie_dma_pkg::dma_desc_t n;
        n = d;
        case (addr)
            ctrl_reg_pkg::ADDR_RD_PCIE_LO: n.pcie_addr[31:0]  = data;
            ctrl_reg_pkg::ADDR_RD_PCIE_HI: n.pcie_addr[63:32] = data;
            ctrl_reg_pkg::ADDR_RD_AXI:     n.axi_addr = data;
            ctrl_reg_pkg::ADDR_RD_LEN:     n.len = data[pcie_dma_pkg::DMA_LEN_W-1:0];
            ctrl_reg_pkg::ADDR_RD_TAG:     n.tag = data[pcie_dma_pkg::DMA_TAG_W-1:0];
            default: ;
        endcase
        return n;
    endfunction

    function automatic ctrl_reg_pkg::reg_word_u status_word(
        input pcie_dma_pkg::dma_status_t s
    );
        ctrl_reg_pkg::reg_word_u w;
        w.raw         = '0;
        w.status.tag  = s.tag;
        w.status.err  = 8'(s.error);
        w.status.done = s.valid;
        return w;
    endfunction

    assign stat_in[0]  = rd_status;
    assign stat_in[1]  = wr_status;
    assign desc_ready  = {wr_desc_ready, rd_desc_ready};
    assign rd_desc     = desc_q[0];
    assign wr_desc     = desc_q[1];
    assign dma_enable  = enable_q[0];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wr_norm[i]  = wr.addr - blk_ofs(i);
            rd_norm[i]  = rd_addr - blk_ofs(i);
            tag_wr[i]   = wr_stb && wr_norm[i] == ctrl_reg_pkg::ADDR_RD_TAG;
            stat_clr[i] = rd_stb && rd_norm[i] == ctrl_reg_pkg::ADDR_RD_STATUS;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (wr_stb) begin
                stage_q[i] <= stage_field(stage_q[i], wr_norm[i], wr.data);
            end
            // launch takes the staged fields together with the new tag
            if (tag_wr[i]) begin
                desc_q[i] <= stage_field(stage_q[i], wr_norm[i], wr.data);
            end
            desc_q[i].valid <= tag_wr[i] || (desc_q[i].valid && !desc_ready[i]);

            if (stat_clr[i]) begin
                stat_q[i].valid <= 1'b0;
            end
            // capture beats a clearing read in the same cycle
            if (stat_in[i].valid) begin
                stat_q[i] <= stat_in[i];
            end
        end

        irq <= rd_status.valid || wr_status.valid;

        if (wr_stb && wr.addr == ctrl_reg_pkg::ADDR_ENABLE) begin
            enable_q <= wr.data;
        end

        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                desc_q[i].valid <= 1'b0;
                stat_q[i]       <= '0;
            end
            irq      <= 1'b0;
            enable_q <= '0;
        end
    end

    always_comb begin
        rd_data.raw = '0;
        case (rd_addr)
            ctrl_reg_pkg::ADDR_ENABLE:    rd_data.raw = enable_q;
            ctrl_reg_pkg::ADDR_RD_STATUS: rd_data = status_word(stat_q[0]);
            ctrl_reg_pkg::ADDR_WR_STATUS: rd_data = status_word(stat_q[1]);
            ctrl_reg_pkg::ADDR_CNT_RQ:    rd_data.raw = cnt_rq;
            ctrl_reg_pkg::ADDR_CNT_RC:    rd_data.raw = cnt_rc;
            ctrl_reg_pkg::ADDR_CNT_CQ:    rd_data.raw = cnt_cq;
            ctrl_reg_pkg::ADDR_CNT_CC:    rd_data.raw = cnt_cc;
            default: ;
        endcase
    end

    for (genvar g = 0; g < 2; g++) begin : g_chk
        // descriptor held for the engine until its ready
        assert property (@(posedge clk) disable iff (rst)
            desc_q[g].valid && !desc_ready[g] && !tag_wr[g] |=> $stable(desc_q[g]));

        // no completion lost to a read that clears in the same cycle
        assert property (@(posedge clk) disable iff (rst)
            stat_clr[g] && stat_in[g].valid |=> stat_q[g].valid);
    end

endmodule

`default_nettype wire

// ==== rtl/tlp_counters.sv ====
// Packet counters for the RQ, RC, CQ and CC links
`timescale 1ns/100ps
`default_nettype none

module tlp_counters (
    input  wire                             clk,
    input  wire                             rst,
    input  wire pcie_dma_pkg::link_beat_t   rq_beat,
    input  wire pcie_dma_pkg::link_beat_t   rc_beat,
    input  wire pcie_dma_pkg::link_beat_t   cq_beat,
    input  wire pcie_dma_pkg::link_beat_t   cc_beat,
    output logic [pcie_dma_pkg::CNT_W-1:0]  cnt_rq,
    output logic [pcie_dma_pkg::CNT_W-1:0]  cnt_rc,
    output logic [pcie_dma_pkg::CNT_W-1:0]  cnt_cq,
    output logic [pcie_dma_pkg::CNT_W-1:0]  cnt_cc
);

    pcie_dma_pkg::link_beat_t       beat  [4];
    logic [pcie_dma_pkg::CNT_W-1:0] cnt_q [4];

    assign beat[0] = rq_beat;
    assign beat[1] = rc_beat;
    assign beat[2] = cq_beat;
    assign beat[3] = cc_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                // last beat accepted, counter wraps
                if (beat[i].valid && beat[i].ready && beat[i].last) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign cnt_rq = cnt_q[0];
    assign cnt_rc = cnt_q[1];
    assign cnt_cq = cnt_q[2];
    assign cnt_cc = cnt_q[3];

endmodule

`default_nettype wire

// ==== rtl/error_pulse_merge.sv ====
// Error pulse merger
// counts simultaneous pulses and replays them one per cycle
`timescale 1ns/100ps
`default_nettype none

module error_pulse_merge (
    input  wire                                clk,
    input  wire                                rst,
    input  wire [pcie_dma_pkg::ERR_SRC_N-1:0]  pulse_in,
    output logic                               pulse_out
);

    logic [pcie_dma_pkg::MERGE_CNT_W-1:0] count_q;
    logic [pcie_dma_pkg::MERGE_CNT_W:0]   total;
    logic [pcie_dma_pkg::MERGE_CNT_W:0]   remain;

    always_comb begin
        total  = {1'b0, count_q} + (pcie_dma_pkg::MERGE_CNT_W + 1)'($countones(pulse_in));
        // one pending pulse leaves with each output pulse
        remain = (total == '0) ? '0 : total - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q   <= '0;
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= total != '0;
            // saturate at the top of the counter
            if (remain[pcie_dma_pkg::MERGE_CNT_W]) begin
                count_q <= '1;
            end else begin
                count_q <= remain[pcie_dma_pkg::MERGE_CNT_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dma_ctrl_top.sv ====
// DMA control plane top
// register slave, control registers, packet counters and error mergers
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl_top (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  aw_valid,
    input  wire ctrl_reg_pkg::reg_wr_t           wr,
    output wire                                  aw_ready,
    output wire                                  w_ready,
    output wire                                  b_valid,
    input  wire                                  b_ready,
    input  wire                                  ar_valid,
    input  wire [ctrl_reg_pkg::REG_ADDR_W-1:0]   ar_addr,
    output wire                                  ar_ready,
    output wire                                  r_valid,
    output wire [ctrl_reg_pkg::REG_DATA_W-1:0]   r_data,
    input  wire                                  r_ready,
    output wire pcie_dma_pkg::dma_desc_t         rd_desc,
    input  wire                                  rd_desc_ready,
    output wire pcie_dma_pkg::dma_desc_t         wr_desc,
    input  wire                                  wr_desc_ready,
    input  wire pcie_dma_pkg::dma_status_t       rd_status,
    input  wire pcie_dma_pkg::dma_status_t       wr_status,
    input  wire pcie_dma_pkg::link_beat_t        rq_beat,
    input  wire pcie_dma_pkg::link_beat_t        rc_beat,
    input  wire pcie_dma_pkg::link_beat_t        cq_beat,
    input  wire pcie_dma_pkg::link_beat_t        cc_beat,
    input  wire [pcie_dma_pkg::ERR_SRC_N-1:0]    err_cor_src,
    input  wire [pcie_dma_pkg::ERR_SRC_N-1:0]    err_uncor_src,
    output wire                                  dma_enable,
    output wire                                  irq,
    output wire                                  err_cor,
    output wire                                  err_uncor
);

    logic                                wr_stb;
    logic                                rd_stb;
    logic [ctrl_reg_pkg::REG_ADDR_W-1:0] rd_addr;
    ctrl_reg_pkg::reg_word_u             rd_data;
    logic [pcie_dma_pkg::CNT_W-1:0]      cnt_rq;
    logic [pcie_dma_pkg::CNT_W-1:0]      cnt_rc;
    logic [pcie_dma_pkg::CNT_W-1:0]      cnt_cq;
    logic [pcie_dma_pkg::CNT_W-1:0]      cnt_cc;

    axil_reg_slave axil_reg_slave_i (
        .clk      (clk),
        .rst      (rst),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_ready  (r_ready),
        .wr_stb   (wr_stb),
        .rd_stb   (rd_stb),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    dma_ctrl_regs dma_ctrl_regs_i (
        .clk           (clk),
        .rst           (rst),
        .wr_stb        (wr_stb),
        .wr            (wr),
        .rd_stb        (rd_stb),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_desc       (rd_desc),
        .wr_desc       (wr_desc),
        .rd_desc_ready (rd_desc_ready),
        .wr_desc_ready (wr_desc_ready),
        .rd_status     (rd_status),
        .wr_status     (wr_status),
        .cnt_rq        (cnt_rq),
        .cnt_rc        (cnt_rc),
        .cnt_cq        (cnt_cq),
        .cnt_cc        (cnt_cc),
        .dma_enable    (dma_enable),
        .irq           (irq)
    );

    tlp_counters tlp_counters_i (
        .clk     (clk),
        .rst     (rst),
        .rq_beat (rq_beat),
        .rc_beat (rc_beat),
        .cq_beat (cq_beat),
        .cc_beat (cc_beat),
        .cnt_rq  (cnt_rq),
        .cnt_rc  (cnt_rc),
        .cnt_cq  (cnt_cq),
        .cnt_cc  (cnt_cc)
    );

    error_pulse_merge err_cor_merge_i (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_cor_src),
        .pulse_out (err_cor)
    );

    error_pulse_merge err_uncor_merge_i (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_uncor_src),
        .pulse_out (err_uncor)
    );

endmodule

`default_nettype wire

// ==== sim/dma_ctrl_top_tb.sv ====
// Testbench for the DMA control plane top
// register table, engine model, random link beats and error bursts
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl_top_tb;

    localparam int N_ROWS  = 23;
    localparam int SEG_B   = 19;
    localparam int N_BEATS = 200;
    localparam int N_BURST = 4;
    // 40 cycles per bus op, counter reads included, plus beats, burst and drain
    localparam int LIMIT   = 40 * (N_ROWS + 4) + N_BEATS + N_BURST + 100;

    localparam logic OP_WR = 1'b1;
    localparam logic OP_RD = 1'b0;

    typedef struct packed {
        logic        is_wr;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } reg_op_t;

    logic                                clk;
    logic                                rst;
    logic                                aw_valid;
    ctrl_reg_pkg::reg_wr_t               wr;
    logic                                aw_ready;
    logic                                w_ready;
    logic                                b_valid;
    logic                                b_ready;
    logic                                ar_valid;
    logic [ctrl_reg_pkg::REG_ADDR_W-1:0] ar_addr;
    logic                                ar_ready;
    logic                                r_valid;
    logic [ctrl_reg_pkg::REG_DATA_W-1:0] r_data;
    logic                                r_ready;
    pcie_dma_pkg::dma_desc_t             rd_desc;
    pcie_dma_pkg::dma_desc_t             wr_desc;
    logic                                rd_desc_ready;
    logic                                wr_desc_ready;
    pcie_dma_pkg::dma_status_t           rd_status;
    pcie_dma_pkg::dma_status_t           wr_status;
    pcie_dma_pkg::link_beat_t            beats [4];
    logic [pcie_dma_pkg::ERR_SRC_N-1:0]  err_cor_src;
    logic [pcie_dma_pkg::ERR_SRC_N-1:0]  err_uncor_src;
    logic                                dma_enable;
    logic                                irq;
    logic                                err_cor;
    logic                                err_uncor;

    integer seed      = 32'hb48e91d9;
    int     errors    = 0;
    int     checks    = 0;
    int     cycles    = 0;
    int     irq_cnt   = 0;
    int     cor_cnt   = 0;
    int     uncor_cnt = 0;

    reg_op_t ops [N_ROWS] = '{
        '{OP_RD, ctrl_reg_pkg::ADDR_CNT_RQ,     32'h0,         32'h0},
        '{OP_RD, ctrl_reg_pkg::ADDR_CNT_RC,     32'h0,         32'h0},
        '{OP_RD, ctrl_reg_pkg::ADDR_CNT_CQ,     32'h0,         32'h0},
        '{OP_RD, ctrl_reg_pkg::ADDR_CNT_CC,     32'h0,         32'h0},
        '{OP_RD, ctrl_reg_pkg::ADDR_RD_STATUS,  32'h0,         32'h0},
        '{OP_RD, ctrl_reg_pkg::ADDR_WR_STATUS,  32'h0,         32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_ENABLE,     32'hA5A5_0001, 32'h0},
        '{OP_RD, ctrl_reg_pkg::ADDR_ENABLE,     32'h0,         32'hA5A5_0001},
        '{OP_RD, 16'h0300,                      32'h0,         32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_RD_PCIE_LO, 32'h1234_5678, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_RD_PCIE_HI, 32'h0000_00AB, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_RD_AXI,     32'h0000_4000, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_RD_LEN,     32'h0000_0200, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_RD_TAG,     32'h0000_005A, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_WR_PCIE_LO, 32'h9ABC_DEF0, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_WR_PCIE_HI, 32'h0000_0001, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_WR_AXI,     32'h0000_8000, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_WR_LEN,     32'h0000_0080, 32'h0},
        '{OP_WR, ctrl_reg_pkg::ADDR_WR_TAG,     32'h0000_00C3, 32'h0},
        // status after the engine completions, second read sees done clear
        '{OP_RD, ctrl_reg_pkg::ADDR_RD_STATUS,  32'h0,         32'h8000_035A},
        '{OP_RD, ctrl_reg_pkg::ADDR_RD_STATUS,  32'h0,         32'h0000_035A},
        '{OP_RD, ctrl_reg_pkg::ADDR_WR_STATUS,  32'h0,         32'h8000_09C3},
        '{OP_RD, ctrl_reg_pkg::ADDR_WR_STATUS,  32'h0,         32'h0000_09C3}
    };

    dma_ctrl_top dma_ctrl_top_i (
        .clk           (clk),
        .rst           (rst),
        .aw_valid      (aw_valid),
        .wr            (wr),
        .aw_ready      (aw_ready),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b_ready       (b_ready),
        .ar_valid      (ar_valid),
        .ar_addr       (ar_addr),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r_data        (r_data),
        .r_ready       (r_ready),
        .rd_desc       (rd_desc),
        .rd_desc_ready (rd_desc_ready),
        .wr_desc       (wr_desc),
        .wr_desc_ready (wr_desc_ready),
        .rd_status     (rd_status),
        .wr_status     (wr_status),
        .rq_beat       (beats[0]),
        .rc_beat       (beats[1]),
        .cq_beat       (beats[2]),
        .cc_beat       (beats[3]),
        .err_cor_src   (err_cor_src),
        .err_uncor_src (err_uncor_src),
        .dma_enable    (dma_enable),
        .irq           (irq),
        .err_cor       (err_cor),
        .err_uncor     (err_uncor)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // pulse counters, sampled mid-cycle
    always @(negedge clk) begin
        if (irq) begin
            irq_cnt++;
        end
        if (err_cor) begin
            cor_cnt++;
        end
        if (err_uncor) begin
            uncor_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_word(input string name, input ctrl_reg_pkg::reg_word_u exp,
                              input ctrl_reg_pkg::reg_word_u act);
        checks++;
        if (act.raw !== exp.raw) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp.raw, act.raw);
        end
    endtask

    task automatic check_desc(input string name, input pcie_dma_pkg::dma_desc_t exp,
                              input pcie_dma_pkg::dma_desc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clk);
        aw_valid  <= 1'b1;
        wr.addr   <= addr;
        wr.data   <= data;
        @(negedge clk);
        while (!aw_ready) begin
            @(negedge clk);
        end
        check_bit("w_ready with aw_ready", 1'b1, w_ready);
        if (!b_valid) begin
            errors++;
            $display("Write to %h was accepted but no response came back", addr);
        end
        @(posedge clk);
        aw_valid <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        @(posedge clk);
        ar_valid <= 1'b1;
        ar_addr  <= addr;
        @(negedge clk);
        while (!ar_ready) begin
            @(negedge clk);
        end
        if (!r_valid) begin
            errors++;
            $display("Read of %h was accepted but no data came back", addr);
        end
        data = r_data;
        @(posedge clk);
        ar_valid <= 1'b0;
    endtask

    task automatic run_rows(input int first, input int last);
        logic [31:0] got;
        for (int i = first; i <= last; i++) begin
            if (ops[i].is_wr) begin
                bus_write(ops[i].addr, ops[i].data);
            end else begin
                bus_read(ops[i].addr, got);
                check_word($sformatf("row %0d addr %h", i, ops[i].addr), ops[i].exp, got);
            end
        end
    endtask

    // engine takes one descriptor
    task automatic engine_accept(input int side);
        @(posedge clk);
        if (side == 0) begin
            rd_desc_ready <= 1'b1;
        end else begin
            wr_desc_ready <= 1'b1;
        end
        @(posedge clk);
        rd_desc_ready <= 1'b0;
        wr_desc_ready <= 1'b0;
        @(negedge clk);
    endtask

    // engine reports one completion, irq must pulse once
    task automatic engine_complete(input int side, input logic [7:0] tag,
                                   input logic [3:0] err);
        pcie_dma_pkg::dma_status_t s;
        int                        irq_before;
        s.tag   = tag;
        s.error = err;
        s.valid = 1'b1;
        @(posedge clk);
        irq_before = irq_cnt;
        if (side == 0) begin
            rd_status <= s;
        end else begin
            wr_status <= s;
        end
        @(posedge clk);
        rd_status <= '0;
        wr_status <= '0;
        repeat (2) @(posedge clk);
        check_count($sformatf("irq pulses for side %0d", side), 1, irq_cnt - irq_before);
    endtask

    initial begin
        logic [31:0]                         v;
        logic [31:0]                         got;
        int                                  exp_cnt [4];
        int                                  exp_cor;
        int                                  exp_uncor;
        pcie_dma_pkg::dma_desc_t             exp_rd;
        pcie_dma_pkg::dma_desc_t             exp_wr;
        logic [ctrl_reg_pkg::REG_ADDR_W-1:0] cnt_addr [4];

        rst           = 1'b1;
        aw_valid      = 1'b0;
        wr            = '0;
        b_ready       = 1'b1;
        ar_valid      = 1'b0;
        ar_addr       = '0;
        r_ready       = 1'b1;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status     = '0;
        wr_status     = '0;
        err_cor_src   = '0;
        err_uncor_src = '0;
        for (int i = 0; i < 4; i++) begin
            beats[i]   = '0;
            exp_cnt[i] = 0;
        end
        exp_cor     = 0;
        exp_uncor   = 0;
        cnt_addr[0] = ctrl_reg_pkg::ADDR_CNT_RQ;
        cnt_addr[1] = ctrl_reg_pkg::ADDR_CNT_RC;
        cnt_addr[2] = ctrl_reg_pkg::ADDR_CNT_CQ;
        cnt_addr[3] = ctrl_reg_pkg::ADDR_CNT_CC;

        exp_rd = '{64'h0000_00AB_1234_5678, 32'h0000_4000, 16'h0200, 8'h5A, 1'b1};
        exp_wr = '{64'h0000_0001_9ABC_DEF0, 32'h0000_8000, 16'h0080, 8'hC3, 1'b1};

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("aw_ready after reset", 1'b0, aw_ready);
        check_bit("w_ready after reset", 1'b0, w_ready);
        check_bit("b_valid after reset", 1'b0, b_valid);
        check_bit("ar_ready after reset", 1'b0, ar_ready);
        check_bit("r_valid after reset", 1'b0, r_valid);
        check_bit("rd_desc valid after reset", 1'b0, rd_desc.valid);
        check_bit("wr_desc valid after reset", 1'b0, wr_desc.valid);
        check_bit("dma_enable after reset", 1'b0, dma_enable);
        check_bit("irq after reset", 1'b0, irq);
        check_bit("err_cor after reset", 1'b0, err_cor);
        check_bit("err_uncor after reset", 1'b0, err_uncor);

        // reset reads, enable, both descriptors launched with readies low
        run_rows(0, SEG_B - 1);
        @(negedge clk);
        check_bit("dma_enable", 1'b1, dma_enable);
        check_desc("rd_desc launched", exp_rd, rd_desc);
        check_desc("wr_desc launched", exp_wr, wr_desc);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_desc("rd_desc held", exp_rd, rd_desc);
        check_desc("wr_desc held", exp_wr, wr_desc);

        engine_accept(0);
        check_bit("rd_desc valid after ready", 1'b0, rd_desc.valid);
        check_desc("wr_desc untouched by rd ready", exp_wr, wr_desc);
        engine_accept(1);
        check_bit("wr_desc valid after ready", 1'b0, wr_desc.valid);

        engine_complete(0, 8'h5A, 4'h3);
        engine_complete(1, 8'hC3, 4'h9);
        run_rows(SEG_B, N_ROWS - 1);

        // random beats, a packet ends where valid, ready and last are all high
        for (int c = 0; c < N_BEATS; c++) begin
            @(posedge clk);
            for (int i = 0; i < 4; i++) begin
                v = $random(seed);
                if (v[2:0] == 3'b111) begin
                    exp_cnt[i]++;
                end
                beats[i] <= pcie_dma_pkg::link_beat_t'(v[2:0]);
            end
        end
        @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            beats[i] <= '0;
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(cnt_addr[i], got);
            check_word($sformatf("counter at %h", cnt_addr[i]), exp_cnt[i], got);
        end

        // short burst keeps the pending total below the saturation point
        for (int c = 0; c < N_BURST; c++) begin
            @(posedge clk);
            v = $random(seed);
            err_cor_src   <= v[2:0];
            err_uncor_src <= v[5:3];
            for (int b = 0; b < 3; b++) begin
                exp_cor   += int'(v[b]);
                exp_uncor += int'(v[b+3]);
            end
        end
        @(posedge clk);
        err_cor_src   <= '0;
        err_uncor_src <= '0;
        @(negedge clk);
        while (err_cor || err_uncor) begin
            @(negedge clk);
        end
        @(posedge clk);
        check_count("err_cor pulses", exp_cor, cor_cnt);
        check_count("err_uncor pulses", exp_uncor, uncor_cnt);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dma_ctrl_top.f ====
rtl/ctrl_reg_pkg.sv
rtl/pcie_dma_pkg.sv
rtl/axil_reg_slave.sv
rtl/dma_ctrl_regs.sv
rtl/tlp_counters.sv
rtl/error_pulse_merge.sv
rtl/dma_ctrl_top.sv
sim/dma_ctrl_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module dma_ctrl_top_tb \
    -f dma_ctrl_top.f \
    -o sim_dma_ctrl

./obj_dir/sim_dma_ctrl | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation passed"
